// ==== hw/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // base opcodes of the supported subset.
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // operand a is zero for lui.
    typedef enum logic {
        opa_rs1  = 1'b0,
        opa_zero = 1'b1
    } opa_sel_e;

    typedef enum logic {
        opb_rs2 = 1'b0,
        opb_imm = 1'b1
    } opb_sel_e;

    // decode to execute bundle.
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        alu_op_e               alu_op;
        opa_sel_e              opa_sel;
        opb_sel_e              opb_sel;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rs1_val;
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       imm;
    } id_ex_t;

    // execute to writeback bundle.
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
    } ex_wb_t;

endpackage

// ==== hw/reg_file.sv ====
module reg_file (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pkg::xlen-1:0]       rs1_val,
    output logic [rv_pkg::xlen-1:0]       rs2_val,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] rd,
    input  logic [rv_pkg::xlen-1:0]       wdata
);

    // x0 has no storage.
    logic [rv_pkg::xlen-1:0] regs [1:rv_pkg::num_regs-1];

    // write data bypasses the array on a same-index read.
    function automatic logic [rv_pkg::xlen-1:0] read_port(
        input logic [rv_pkg::reg_addr_w-1:0] addr
    );
        logic [rv_pkg::xlen-1:0] val;
        if (addr == '0)
            val = '0;
        else if (we && rd == addr)
            val = wdata;
        else
            val = regs[addr];
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < rv_pkg::num_regs; i++)
                regs[i] <= '0;
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    always_comb begin
        rs1_val = read_port(rs1);
        rs2_val = read_port(rs2);
    end

endmodule

// ==== hw/decode_stage.sv ====
module decode_stage (
    input  logic                          clk,
    input  logic                          in_valid,
    input  logic                          hold,
    input  logic [31:0]                   in_instr,
    output logic [rv_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_pkg::reg_addr_w-1:0] rs2,
    input  logic [rv_pkg::xlen-1:0]       rs1_val,
    input  logic [rv_pkg::xlen-1:0]       rs2_val,
    output rv_pkg::id_ex_t                id
);

    rv_pkg::opcode_e         opcode;
    rv_pkg::alu_op_e         alu_op;
    logic [2:0]              funct3;
    logic                    alt;
    logic                    legal;
    logic [rv_pkg::xlen-1:0] imm_i;
    logic [rv_pkg::xlen-1:0] imm_u;

    assign opcode = rv_pkg::opcode_e'(in_instr[6:0]);
    assign funct3 = in_instr[14:12];
    assign alt    = in_instr[30];
    assign rs1    = in_instr[19:15];
    assign rs2    = in_instr[24:20];

    assign imm_i = {{(rv_pkg::xlen-12){in_instr[31]}}, in_instr[31:20]};
    assign imm_u = {in_instr[31:12], 12'b0};

    // funct7 bit 30 selects sub only for register ops, sra for both.
    always_comb begin
        case (funct3)
            3'b000: alu_op = (opcode == rv_pkg::op_reg && alt) ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001: alu_op = rv_pkg::alu_sll;
            3'b010: alu_op = rv_pkg::alu_slt;
            3'b011: alu_op = rv_pkg::alu_sltu;
            3'b100: alu_op = rv_pkg::alu_xor;
            3'b101: alu_op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110: alu_op = rv_pkg::alu_or;
            default: alu_op = rv_pkg::alu_and;
        endcase
        if (opcode == rv_pkg::op_lui)
            alu_op = rv_pkg::alu_add;
    end

    always_comb begin
        legal      = 1'b1;
        id.opa_sel = rv_pkg::opa_rs1;
        id.opb_sel = rv_pkg::opb_imm;
        id.imm     = imm_i;
        case (opcode)
            rv_pkg::op_reg: begin
                id.opb_sel = rv_pkg::opb_rs2;
            end
            rv_pkg::op_imm: begin
                id.opb_sel = rv_pkg::opb_imm;
            end
            rv_pkg::op_lui: begin
                id.opa_sel = rv_pkg::opa_zero;
                id.imm     = imm_u;
            end
            default: begin
                legal = 1'b0;
            end
        endcase

        // illegal words go down the pipe as bubbles.
        id.valid   = in_valid && legal;
        id.illegal = in_valid && !legal;
        id.alu_op  = alu_op;
        id.rs1     = rs1;
        id.rs2     = rs2;
        id.rd      = in_instr[11:7];
        id.rs1_val = rs1_val;
        id.rs2_val = rs2_val;
    end

    // nothing may be issued while the pipe is frozen.
    issue_during_hold: assert property (@(posedge clk) !(in_valid && hold))
        else $error("in_valid high while hold is high");

endmodule

// ==== hw/stage_regs.sv ====
module id_ex_reg (
    input  logic           clk,
    input  logic           rst,
    input  logic           hold,
    input  rv_pkg::id_ex_t d,
    output rv_pkg::id_ex_t q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '{valid:   1'b0,
                   illegal: 1'b0,
                   alu_op:  rv_pkg::alu_add,
                   opa_sel: rv_pkg::opa_rs1,
                   opb_sel: rv_pkg::opb_imm,
                   rs1:     '0,
                   rs2:     '0,
                   rd:      '0,
                   rs1_val: '0,
                   rs2_val: '0,
                   imm:     '0};
        end else if (!hold) begin
            q <= d;
        end
    end

    // decode marks an illegal word as a bubble.
    valid_xor_illegal: assert property (@(posedge clk) disable iff (rst) !(q.valid && q.illegal))
        else $error("id_ex holds an instruction both valid and illegal");

endmodule

module ex_wb_reg (
    input  logic           clk,
    input  logic           rst,
    input  logic           hold,
    input  rv_pkg::ex_wb_t d,
    output rv_pkg::ex_wb_t q,
    output logic           commit,
    output logic           fault
);

    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '{valid: 1'b0, illegal: 1'b0, rd: '0, result: '0};
        end else if (!hold) begin
            q <= d;
        end
    end

    // frozen contents are reported once, after hold drops.
    assign commit = q.valid && !hold;
    assign fault  = q.illegal && !hold;

    commit_xor_fault: assert property (@(posedge clk) disable iff (rst) !(commit && fault))
        else $error("writeback reports commit and fault together");

endmodule

// ==== hw/exec_stage.sv ====
module exec_stage (
    input  rv_pkg::id_ex_t id,
    input  rv_pkg::ex_wb_t fwd,
    input  logic           fwd_commit,
    output rv_pkg::ex_wb_t ex
);

    logic [rv_pkg::xlen-1:0] rs1_val;
    logic [rv_pkg::xlen-1:0] rs2_val;
    logic [rv_pkg::xlen-1:0] opa;
    logic [rv_pkg::xlen-1:0] opb;
    logic [rv_pkg::xlen-1:0] result;
    logic [4:0]              shamt;
    logic                    fwd_hit1;
    logic                    fwd_hit2;

    // previous instruction's result, older ones come through the register file.
    assign fwd_hit1 = fwd_commit && fwd.rd != '0 && fwd.rd == id.rs1;
    assign fwd_hit2 = fwd_commit && fwd.rd != '0 && fwd.rd == id.rs2;

    assign rs1_val = fwd_hit1 ? fwd.result : id.rs1_val;
    assign rs2_val = fwd_hit2 ? fwd.result : id.rs2_val;

    assign opa   = (id.opa_sel == rv_pkg::opa_zero) ? '0 : rs1_val;
    assign opb   = (id.opb_sel == rv_pkg::opb_imm) ? id.imm : rs2_val;
    assign shamt = opb[4:0];

    always_comb begin
        case (id.alu_op)
            rv_pkg::alu_add:  result = opa + opb;
            rv_pkg::alu_sub:  result = opa - opb;
            rv_pkg::alu_sll:  result = opa << shamt;
            rv_pkg::alu_slt:  result = {{(rv_pkg::xlen-1){1'b0}}, $signed(opa) < $signed(opb)};
            rv_pkg::alu_sltu: result = {{(rv_pkg::xlen-1){1'b0}}, opa < opb};
            rv_pkg::alu_xor:  result = opa ^ opb;
            rv_pkg::alu_srl:  result = opa >> shamt;
            rv_pkg::alu_sra:  result = $unsigned($signed(opa) >>> shamt);
            rv_pkg::alu_or:   result = opa | opb;
            default:          result = opa & opb;
        endcase
    end

    assign ex.valid   = id.valid;
    assign ex.illegal = id.illegal;
    assign ex.rd      = id.rd;
    assign ex.result  = result;

endmodule

// ==== hw/alu_pipe.sv ====
module alu_pipe (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          hold,
    input  logic                          in_valid,
    input  logic [31:0]                   in_instr,
    output logic                          wb_valid,
    output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]       wb_data,
    output logic                          err
);

    logic [rv_pkg::reg_addr_w-1:0] rs1;
    logic [rv_pkg::reg_addr_w-1:0] rs2;
    logic [rv_pkg::xlen-1:0]       rs1_val;
    logic [rv_pkg::xlen-1:0]       rs2_val;
    rv_pkg::id_ex_t                id_d;
    rv_pkg::id_ex_t                id_q;
    rv_pkg::ex_wb_t                ex_d;
    rv_pkg::ex_wb_t                wb_q;

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .we      (wb_valid),
        .rd      (wb_q.rd),
        .wdata   (wb_q.result)
    );

    decode_stage u_decode (
        .clk      (clk),
        .in_valid (in_valid),
        .hold     (hold),
        .in_instr (in_instr),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .id       (id_d)
    );

    id_ex_reg u_id_ex (
        .clk  (clk),
        .rst  (rst),
        .hold (hold),
        .d    (id_d),
        .q    (id_q)
    );

    // forwarding comes straight from the writeback register.
    exec_stage u_exec (
        .id         (id_q),
        .fwd        (wb_q),
        .fwd_commit (wb_valid),
        .ex         (ex_d)
    );

    ex_wb_reg u_ex_wb (
        .clk    (clk),
        .rst    (rst),
        .hold   (hold),
        .d      (ex_d),
        .q      (wb_q),
        .commit (wb_valid),
        .fault  (err)
    );

    assign wb_rd   = wb_q.rd;
    assign wb_data = wb_q.result;

endmodule

// ==== verif/alu_pipe_tb.sv ====
module alu_pipe_tb;

    typedef struct {
        logic [31:0] instr;
        int          hold;
        bit          check;
        int          test;
    } row_t;

    typedef struct {
        bit                            illegal;
        bit                            check;
        int                            test;
        logic [rv_pkg::reg_addr_w-1:0] rd;
        logic [rv_pkg::xlen-1:0]       data;
    } exp_t;

    logic                          clk;
    logic                          rst;
    logic                          hold;
    logic                          in_valid;
    logic [31:0]                   in_instr;
    logic                          wb_valid;
    logic [rv_pkg::reg_addr_w-1:0] wb_rd;
    logic [rv_pkg::xlen-1:0]       wb_data;
    logic                          err;

    row_t        rows [$];
    exp_t        exp_tab [];
    logic [31:0] model_regs [rv_pkg::num_regs];
    int          acc_cycle [$];
    int          acc_hold [$];
    string       test_name [7] = '{"operand load", "register ops", "immediate ops",
                                   "dependent chain", "lui and x0", "illegal opcode", "hold"};
    int          test_rows [7];
    int          test_done [7];
    int          test_err [7];
    int          total_hold;
    int          issued;
    int          popped;
    int          cur_test;
    int          cycle_cnt;
    int          hold_cnt;
    int          check_cnt;
    int          err_cnt;
    int          cycle_limit = 1000;

    alu_pipe UUT (
        .clk      (clk),
        .rst      (rst),
        .hold     (hold),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .err      (err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_pkg::op_imm};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rv_pkg::op_lui};
    endfunction

    function automatic bit is_legal(input logic [31:0] instr);
        return instr[6:0] == rv_pkg::op_reg || instr[6:0] == rv_pkg::op_imm
            || instr[6:0] == rv_pkg::op_lui;
    endfunction

    // result of one instruction against the model registers.
    function automatic logic [31:0] ref_result(input logic [31:0] instr);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        alt;
        a   = model_regs[instr[19:15]];
        alt = instr[30];
        if (instr[6:0] == rv_pkg::op_reg) begin
            b = model_regs[instr[24:20]];
        end else begin
            b = {{20{instr[31]}}, instr[31:20]};
            // bit 30 belongs to the immediate except for right shifts.
            if (instr[14:12] != 3'b101)
                alt = 1'b0;
        end
        case (instr[14:12])
            3'b000: res = alt ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = {31'b0, $signed(a) < $signed(b)};
            3'b011: res = {31'b0, a < b};
            3'b100: res = a ^ b;
            3'b101: res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        if (instr[6:0] == rv_pkg::op_lui)
            res = {instr[31:12], 12'b0};
        return res;
    endfunction

    task automatic add_row(input logic [31:0] instr, input int hold_cycles, input bit check,
                           input int test);
        row_t r;
        r.instr = instr;
        r.hold  = hold_cycles;
        r.check = check;
        r.test  = test;
        rows.push_back(r);
        test_rows[test]++;
        total_hold += hold_cycles;
    endtask

    task automatic build_table();
        logic [31:0] r;
        foreach (model_regs[i])
            model_regs[i] = '0;
        // x1 and x4 positive, x2 negative, x3 an odd shift amount.
        r = $urandom();
        add_row(u_type({1'b0, r[30:12]}, 5'd1), 0, 1'b1, 0);
        add_row(i_type({1'b0, r[10:0]}, 5'd1, 3'b000, 5'd1), 0, 1'b1, 0);
        r = $urandom();
        add_row(u_type({1'b1, r[30:12]}, 5'd2), 0, 1'b1, 0);
        add_row(i_type(r[11:0], 5'd2, 3'b000, 5'd2), 0, 1'b1, 0);
        r = $urandom();
        add_row(i_type({7'b0, r[4:1], 1'b1}, 5'd0, 3'b000, 5'd3), 0, 1'b1, 0);
        r = $urandom();
        add_row(u_type({1'b0, r[31:13]}, 5'd4), 0, 1'b1, 0);
        add_row(i_type(r[11:0], 5'd4, 3'b000, 5'd4), 0, 1'b1, 0);
        add_row(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd5), 0, 1'b1, 1);
        add_row(r_type(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd6), 0, 1'b1, 1);
        add_row(r_type(7'b0000000, 5'd3, 5'd1, 3'b001, 5'd7), 0, 1'b1, 1);
        add_row(r_type(7'b0000000, 5'd1, 5'd2, 3'b010, 5'd8), 0, 1'b1, 1);
        add_row(r_type(7'b0000000, 5'd1, 5'd2, 3'b011, 5'd9), 0, 1'b1, 1);
        add_row(r_type(7'b0000000, 5'd2, 5'd1, 3'b100, 5'd10), 0, 1'b1, 1);
        add_row(r_type(7'b0000000, 5'd3, 5'd2, 3'b101, 5'd11), 0, 1'b1, 1);
        add_row(r_type(7'b0100000, 5'd3, 5'd2, 3'b101, 5'd12), 0, 1'b1, 1);
        add_row(r_type(7'b0000000, 5'd4, 5'd1, 3'b110, 5'd13), 0, 1'b1, 1);
        add_row(r_type(7'b0000000, 5'd4, 5'd2, 3'b111, 5'd14), 0, 1'b1, 1);
        r = $urandom();
        add_row(i_type(r[11:0], 5'd2, 3'b000, 5'd15), 0, 1'b1, 2);
        add_row(i_type(r[23:12], 5'd2, 3'b010, 5'd16), 0, 1'b1, 2);
        add_row(i_type(12'hfff, 5'd1, 3'b011, 5'd17), 0, 1'b1, 2);
        add_row(i_type(r[31:20], 5'd1, 3'b100, 5'd18), 0, 1'b1, 2);
        r = $urandom();
        add_row(i_type(r[11:0], 5'd2, 3'b110, 5'd19), 0, 1'b1, 2);
        add_row(i_type(r[23:12], 5'd4, 3'b111, 5'd20), 0, 1'b1, 2);
        add_row(i_type({7'b0000000, r[28:24]}, 5'd1, 3'b001, 5'd21), 0, 1'b1, 2);
        add_row(i_type({7'b0000000, r[4:0]}, 5'd2, 3'b101, 5'd22), 0, 1'b1, 2);
        add_row(i_type({7'b0100000, r[4:0]}, 5'd2, 3'b101, 5'd23), 0, 1'b1, 2);
        // distance one and two dependences.
        add_row(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd24), 0, 1'b1, 3);
        add_row(r_type(7'b0100000, 5'd4, 5'd24, 3'b000, 5'd25), 0, 1'b1, 3);
        add_row(r_type(7'b0000000, 5'd25, 5'd24, 3'b100, 5'd26), 0, 1'b1, 3);
        add_row(r_type(7'b0000000, 5'd3, 5'd26, 3'b001, 5'd27), 0, 1'b1, 3);
        add_row(r_type(7'b0000000, 5'd26, 5'd27, 3'b000, 5'd24), 0, 1'b1, 3);
        r = $urandom();
        add_row(u_type(r[31:12], 5'd28), 0, 1'b1, 4);
        add_row(i_type(12'd5, 5'd28, 3'b000, 5'd0), 0, 1'b0, 4);
        add_row(r_type(7'b0000000, 5'd28, 5'd0, 3'b000, 5'd29), 0, 1'b1, 4);
        add_row(r_type(7'b0000000, 5'd0, 5'd29, 3'b110, 5'd29), 0, 1'b1, 4);
        // a load word is outside the subset.
        add_row(i_type(12'd7, 5'd0, 3'b000, 5'd30), 0, 1'b1, 5);
        add_row({12'h004, 5'd1, 3'b010, 5'd30, 7'b0000011}, 0, 1'b1, 5);
        add_row(r_type(7'b0000000, 5'd30, 5'd30, 3'b000, 5'd31), 0, 1'b1, 5);
        add_row(i_type(12'd1, 5'd30, 3'b000, 5'd30), 0, 1'b1, 5);
        r = $urandom();
        add_row(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd5), 0, 1'b1, 6);
        add_row(r_type(7'b0100000, 5'd1, 5'd5, 3'b000, 5'd6), 1, 1'b1, 6);
        add_row(r_type(7'b0000000, 5'd5, 5'd6, 3'b100, 5'd7), 2, 1'b1, 6);
        add_row(i_type(r[11:0], 5'd7, 3'b000, 5'd8), 3, 1'b1, 6);
        add_row(r_type(7'b0000000, 5'd7, 5'd8, 3'b111, 5'd9), 1, 1'b1, 6);
    endtask

    task automatic model_issue(input row_t r);
        exp_t e;
        e.illegal = 1'b0;
        e.check   = r.check;
        e.test    = r.test;
        e.rd      = r.instr[11:7];
        e.data    = '0;
        if (is_legal(r.instr)) begin
            e.data = ref_result(r.instr);
            if (e.rd != 5'd0)
                model_regs[e.rd] = e.data;
        end else begin
            e.illegal = 1'b1;
        end
        exp_tab[issued] = e;
        issued++;
    endtask

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        check_cnt++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            err_cnt++;
            test_err[cur_test]++;
        end
    endtask

    task automatic compare_writeback();
        exp_t e;
        int   lat;
        int   lat_exp;
        if (popped >= issued) begin
            $display("unexpected writeback pulse at %0t, rd %0d, data %h", $time, wb_rd, wb_data);
            err_cnt++;
            return;
        end
        e        = exp_tab[popped];
        cur_test = e.test;
        lat      = cycle_cnt - acc_cycle.pop_front();
        // every hold cycle in flight delays the result by one.
        lat_exp  = 2 + hold_cnt - acc_hold.pop_front();
        check_val("err", {31'b0, e.illegal}, {31'b0, err});
        check_val("wb_valid", {31'b0, !e.illegal}, {31'b0, wb_valid});
        if (!e.illegal)
            check_val("wb_rd", {27'b0, e.rd}, {27'b0, wb_rd});
        if (!e.illegal && e.check)
            check_val("wb_data", e.data, wb_data);
        check_val("latency", lat_exp, lat);
        popped++;
        test_done[e.test]++;
        if (test_done[e.test] == test_rows[e.test])
            $display("test %0d (%s) done: %0d results, %0d errors", e.test, test_name[e.test],
                     test_rows[e.test], test_err[e.test]);
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (!rst) begin
            if (hold)
                hold_cnt = hold_cnt + 1;
            if (in_valid) begin
                acc_cycle.push_back(cycle_cnt);
                acc_hold.push_back(hold_cnt);
            end
            if (wb_valid || err)
                compare_writeback();
        end
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout at cycle %0d with %0d results still outstanding",
                     cycle_cnt, issued - popped);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        rst      = 1'b1;
        hold     = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        void'($urandom(97592));
        build_table();
        exp_tab     = new[rows.size()];
        cycle_limit = 16 + rows.size() + total_hold + 20;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) begin
            if (rows[i].hold > 0) begin
                in_valid = 1'b0;
                hold     = 1'b1;
                repeat (rows[i].hold) @(negedge clk);
                hold = 1'b0;
            end
            in_valid = 1'b1;
            in_instr = rows[i].instr;
            model_issue(rows[i]);
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_instr = '0;
        while (popped < issued)
            @(negedge clk);
        // late strays would show up here.
        repeat (4) @(negedge clk);
        $display("%0d tests, %0d results, %0d checks, %0d errors",
                 7, popped, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== sources.f ====
hw/rv_pkg.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/stage_regs.sv
hw/exec_stage.sv
hw/alu_pipe.sv
verif/alu_pipe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the alu_pipe testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary -f sources.f --top-module alu_pipe_tb -o alu_pipe_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/alu_pipe_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '** PASS **'; then
    exit 0
else
    exit 1
fi
